// ==== sim/bar_testdata.txt ====
# name vld beat_data keepdw first last bar_hit bar_en tx_ready exp_cpl exp_cpl_data lat
# All hex except name and lat; lat is cycles from beat to o_tx_valid, 0 = unchecked
fresh_read 1 0000000000000040ABCD010F00000001 7 1 1 01 1 1 1 00000000ABCD0140341200044A000001 0
partial_write 1 1122334400000100ABCD020540000001 f 1 1 01 1 1 0 00000000000000000000000000000000 0
partial_write 1 556677EE00000100ABCD040840000001 f 1 1 01 1 1 0 00000000000000000000000000000000 0
partial_write 1 0000000000000100ABCD030F00000001 7 1 1 01 1 1 1 110033EEABCD0300341200044A000001 0
loopback 1 000000001234567C5A5A7E0F00000001 7 1 1 02 1 1 1 7C5634125A5A7E7C341200044A000001 0
bad_requests 1 0000000000000040ABCD080F00000001 7 1 1 01 0 1 0 00000000000000000000000000000000 0
bad_requests 1 0000000000000040ABCD090F00000001 7 1 1 08 1 1 0 00000000000000000000000000000000 0
bad_requests 1 0000000000000040ABCD0A0F00000002 7 1 1 01 1 1 0 00000000000000000000000000000000 0
bad_requests 1 0000004000000000ABCD0B0F20000001 f 1 1 01 1 1 0 00000000000000000000000000000000 0
credit_limit 1 0000000000001000ABCD200F00000001 7 1 1 02 1 0 1 00100000ABCD2000341200044A000001 0
credit_limit 1 0000000000001004ABCD210F00000001 7 1 1 02 1 0 1 04100000ABCD2104341200044A000001 0
credit_limit 1 0000000000001008ABCD220F00000001 7 1 1 02 1 0 1 08100000ABCD2208341200044A000001 0
credit_limit 1 000000000000100CABCD230F00000001 7 1 1 02 1 0 1 0C100000ABCD230C341200044A000001 0
credit_limit 1 0000000000001010ABCD240F00000001 7 1 1 02 1 0 1 10100000ABCD2410341200044A000001 0
credit_limit 1 0000000000001014ABCD250F00000001 7 1 1 02 1 0 1 14100000ABCD2514341200044A000001 0
credit_limit 1 0000000000001018ABCD260F00000001 7 1 1 02 1 0 1 18100000ABCD2618341200044A000001 0
credit_limit 1 000000000000101CABCD270F00000001 7 1 1 02 1 0 1 1C100000ABCD271C341200044A000001 0
credit_limit 1 0000000000001020ABCD280F00000001 7 1 1 02 1 0 0 00000000000000000000000000000000 0
credit_limit 1 0000000000001024ABCD290F00000001 7 1 1 02 1 0 0 00000000000000000000000000000000 0
credit_limit 0 00000000000000000000000000000000 0 0 0 00 1 1 0 00000000000000000000000000000000 0
latency 1 0000000000000040ABCD060F00000001 7 1 1 01 1 1 1 00000000ABCD0640341200044A000001 4

// ==== tb.f ====
+incdir+verilog
verilog/bar_pkg.sv
verilog/tlp_bar_rx.sv
verilog/bar_mem_4k.sv
verilog/bar_responders.sv
verilog/cpl_builder.sv
verilog/bar_controller_top.sv
sim/tb_clock.sv
sim/bar_controller_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f tb.f \
    --top-module bar_controller_tb -o bar_controller_sim

out=$(./obj_dir/bar_controller_sim 2>&1) || true
echo "$out"

if echo "$out" | grep -q "TEST RESULT: PASS"; then
    exit 0
fi
exit 1

// ==== sim/bar_controller_tb.sv ====
`timescale 1ns/1ps
`include "bar_consts.svh"

module bar_controller_tb;

    localparam logic [15:0] PCIE_ID = 16'h1234;
    localparam int RESET_CYCLES = 5;
    localparam int QUIET_CYCLES = 20;
    localparam int WAIT_LIMIT   = 30;

    // One line of the vector file
    typedef struct packed {
        logic                   vld;
        logic [`BAR_TLP_W-1:0]  data;
        logic [3:0]             keepdw;
        logic                   first;
        logic                   last;
        logic [6:0]             bar_hit;
        logic                   bar_en;
        logic                   tx_ready;
        logic                   cpl_exp;
        logic [`BAR_TLP_W-1:0]  cpl_data;
        logic [7:0]             lat;
    } vec_t;

    logic               clk;
    logic               rst;
    bar_pkg::tlp_beat_t i_rx;
    logic               i_rx_valid;
    logic               i_bar_en;
    bar_pkg::pcie_id_t  i_pcie_id;
    bar_pkg::tlp_out_t  o_tx;
    logic               o_tx_valid;
    logic               i_tx_ready;

    string                  rec_name [$];
    vec_t                   rec_vec [$];
    logic [`BAR_TLP_W-1:0]  exp_q [$];
    string                  cur_test = "reset_idle";
    int                     test_errors = 0;
    int                     tests_passed = 0;
    int                     tests_failed = 0;
    int                     cycle_count = 0;
    int                     cycle_limit = 100000;

    tb_clock clock_gen (
        .o_clk (clk)
    );

    bar_controller_top bar_controller_top_inst (
        .clk        (clk),
        .rst        (rst),
        .i_rx       (i_rx),
        .i_rx_valid (i_rx_valid),
        .i_bar_en   (i_bar_en),
        .i_pcie_id  (i_pcie_id),
        .o_tx       (o_tx),
        .o_tx_valid (o_tx_valid),
        .i_tx_ready (i_tx_ready)
    );

    // ------------------------------------------------------------
    // Vector file reader
    // ------------------------------------------------------------
    task automatic load_records(output bit ok);
        int             fd;
        int             n;
        string          line;
        string          name;
        vec_t           v;
        logic           vld_f, first_f, last_f, en_f, rdy_f, exp_f;
        logic [3:0]     keep_f;
        logic [6:0]     hit_f;
        logic [127:0]   data_f, cpl_f;
        int             lat_f;
        ok = 1'b1;
        fd = $fopen("sim/bar_testdata.txt", "r");
        if (fd == 0) begin
            $display("ERROR: cannot open sim/bar_testdata.txt");
            ok = 1'b0;
        end else begin
            while ($fgets(line, fd) != 0) begin
                // Skip comments and blank lines
                if (line.len() > 1 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %d", name, vld_f,
                                data_f, keep_f, first_f, last_f, hit_f, en_f, rdy_f, exp_f,
                                cpl_f, lat_f);
                    if (n != 12) begin
                        $display("ERROR: malformed vector line: %s", line);
                        ok = 1'b0;
                    end
                    v.vld      = vld_f;
                    v.data     = data_f;
                    v.keepdw   = keep_f;
                    v.first    = first_f;
                    v.last     = last_f;
                    v.bar_hit  = hit_f;
                    v.bar_en   = en_f;
                    v.tx_ready = rdy_f;
                    v.cpl_exp  = exp_f;
                    v.cpl_data = cpl_f;
                    v.lat      = 8'(lat_f);
                    rec_name.push_back(name);
                    rec_vec.push_back(v);
                end
            end
            $fclose(fd);
            if (rec_vec.size() == 0) begin
                $display("ERROR: no test vectors found");
                ok = 1'b0;
            end
        end
    endtask

    task automatic finish_test(input string name);
        if (test_errors == 0) begin
            tests_passed++;
            $display("test %s passed", name);
        end else begin
            tests_failed++;
            $display("test %s failed with %0d errors", name, test_errors);
        end
        test_errors = 0;
    endtask

    // ------------------------------------------------------------
    // One beat, then wait for its completions or a quiet window
    // ------------------------------------------------------------
    task automatic run_record(input vec_t v);
        bar_pkg::tlp_beat_t beat;
        int                 waited;
        int                 quiet;
        int                 lat_got;
        beat.data    = v.data;
        beat.keepdw  = v.keepdw;
        beat.first   = v.first;
        beat.last    = v.last;
        beat.bar_hit = v.bar_hit;
        waited  = 0;
        lat_got = 0;
        quiet   = v.cpl_exp ? 0 : QUIET_CYCLES;
        @(posedge clk);
        i_rx       <= beat;
        i_rx_valid <= v.vld;
        i_bar_en   <= v.bar_en;
        i_tx_ready <= v.tx_ready;
        if (v.cpl_exp) begin
            exp_q.push_back(v.cpl_data);
        end
        if (v.tx_ready) begin
            while ((exp_q.size() != 0 || waited < quiet) && waited < WAIT_LIMIT) begin
                @(posedge clk);
                i_rx_valid <= 1'b0;
                waited++;
                @(negedge clk);
                if (o_tx_valid && lat_got == 0) begin
                    lat_got = waited;
                end
            end
            if (exp_q.size() != 0) begin
                $display("ERROR: test %s: %0d expected completions never arrived",
                         cur_test, exp_q.size());
                exp_q.delete();
                test_errors++;
            end
            if (v.lat != 0 && lat_got != int'(v.lat)) begin
                $display("FAIL %s: expected latency %0d, got %0d", cur_test, v.lat, lat_got);
                test_errors++;
            end
        end else begin
            // Stalled output, completions pile up in the FIFO
            @(posedge clk);
            i_rx_valid <= 1'b0;
        end
    endtask

    // Completion checker, sampled mid-cycle
    always @(negedge clk) begin : check_tx
        logic [`BAR_TLP_W-1:0] want;
        if (!rst && o_tx_valid && i_tx_ready) begin
            if (exp_q.size() == 0) begin
                $display("ERROR: test %s: unexpected completion with data %h",
                         cur_test, o_tx.data);
                test_errors++;
            end else begin
                want = exp_q.pop_front();
                if (o_tx.data !== want) begin
                    $display("FAIL %s: expected %h, got %h", cur_test, want, o_tx.data);
                    test_errors++;
                end
                if (o_tx.keepdw !== 4'hF || o_tx.last !== 1'b1) begin
                    $display("FAIL %s: expected keepdw/last f/1, got %h/%b",
                             cur_test, o_tx.keepdw, o_tx.last);
                    test_errors++;
                end
            end
        end
    end

    // Run limit
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("ERROR: run did not finish within %0d cycles", cycle_limit);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    // ------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------
    initial begin : main_seq
        bit ok;
        int i;
        rst        = 1'b1;
        i_rx       = '0;
        i_rx_valid = 1'b0;
        i_bar_en   = 1'b0;
        i_pcie_id  = PCIE_ID;
        i_tx_ready = 1'b1;
        load_records(ok);
        if (!ok) begin
            $display("ERROR: test vectors could not be loaded");
            $display("TEST RESULT: FAIL");
        end else begin
            cycle_limit = 40 * rec_vec.size() + 2 * RESET_CYCLES;
            repeat (RESET_CYCLES) @(posedge clk);
            rst <= 1'b0;
            // No completion may appear out of reset
            repeat (5) begin
                @(negedge clk);
                if (o_tx_valid !== 1'b0) begin
                    $display("FAIL reset_idle: expected o_tx_valid 0, got %b", o_tx_valid);
                    test_errors++;
                end
            end
            finish_test("reset_idle");
            for (i = 0; i < rec_vec.size(); i++) begin
                if (i > 0 && rec_name[i] != rec_name[i-1]) begin
                    finish_test(rec_name[i-1]);
                end
                cur_test = rec_name[i];
                run_record(rec_vec[i]);
            end
            finish_test(rec_name[rec_vec.size()-1]);
            $display("Tests run %0d, passed %0d, failed %0d",
                     tests_passed + tests_failed, tests_passed, tests_failed);
            if (tests_failed == 0) begin
                $display("TEST RESULT: PASS");
            end else begin
                $display("TEST RESULT: FAIL");
            end
        end
        $finish;
    end

endmodule

// ==== sim/tb_clock.sv ====
`timescale 1ns/1ps

// Free-running testbench clock
module tb_clock #(
    parameter real PERIOD_NS = 10.0
) (
    output logic o_clk
);

    initial begin
        o_clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2.0) o_clk = ~o_clk;
        end
    end

endmodule

// ==== verilog/bar_controller_top.sv ====
`timescale 1ns/1ps

module bar_controller_top (
    input  logic                clk,
    input  logic                rst,
    input  bar_pkg::tlp_beat_t  i_rx,
    input  logic                i_rx_valid,
    input  logic                i_bar_en,
    input  bar_pkg::pcie_id_t   i_pcie_id,
    output bar_pkg::tlp_out_t   o_tx,
    output logic                o_tx_valid,
    input  logic                i_tx_ready
);

    bar_pkg::wr_req_t   wr_req;
    logic               wr_valid;
    bar_pkg::rd_req_t   rd_req;
    logic               rd_valid;
    bar_pkg::rd_rsp_t   rsp;
    logic               rsp_valid;
    logic               rd_credit;

    tlp_bar_rx tlp_bar_rx_inst (
        .clk         (clk),
        .rst         (rst),
        .i_rx        (i_rx),
        .i_rx_valid  (i_rx_valid),
        .i_bar_en    (i_bar_en),
        .i_rd_credit (rd_credit),
        .o_wr_req    (wr_req),
        .o_wr_valid  (wr_valid),
        .o_rd_req    (rd_req),
        .o_rd_valid  (rd_valid)
    );

    bar_responders bar_responders_inst (
        .clk         (clk),
        .rst         (rst),
        .i_wr_req    (wr_req),
        .i_wr_valid  (wr_valid),
        .i_rd_req    (rd_req),
        .i_rd_valid  (rd_valid),
        .o_rsp       (rsp),
        .o_rsp_valid (rsp_valid)
    );

    cpl_builder cpl_builder_inst (
        .clk         (clk),
        .rst         (rst),
        .i_pcie_id   (i_pcie_id),
        .i_rsp       (rsp),
        .i_rsp_valid (rsp_valid),
        .i_rd_accept (rd_valid),
        .o_rd_credit (rd_credit),
        .o_tx        (o_tx),
        .o_tx_valid  (o_tx_valid),
        .i_tx_ready  (i_tx_ready)
    );

endmodule

// ==== verilog/cpl_builder.sv ====
`timescale 1ns/1ps
`include "bar_consts.svh"

module cpl_builder (
    input  logic                clk,
    input  logic                rst,
    input  bar_pkg::pcie_id_t   i_pcie_id,
    input  bar_pkg::rd_rsp_t    i_rsp,
    input  logic                i_rsp_valid,
    input  logic                i_rd_accept,
    output logic                o_rd_credit,
    output bar_pkg::tlp_out_t   o_tx,
    output logic                o_tx_valid,
    input  logic                i_tx_ready
);

    localparam int PTR_W = $clog2(`BAR_CPL_DEPTH);
    localparam int CNT_W = $clog2(`BAR_CPL_DEPTH + 1);
    localparam logic [CNT_W-1:0] DEPTH_C = CNT_W'(`BAR_CPL_DEPTH);

    bar_pkg::tlp_out_t  cpl_beat;
    bar_pkg::tlp_out_t  fifo_mem [`BAR_CPL_DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   fifo_count;
    logic [CNT_W-1:0]   reserved;
    logic               pop;

    // ------------------------------------------------------------
    // CplD formatting, single DW with byte count 4
    // ------------------------------------------------------------
    always_comb begin
        cpl_beat.data[31:0]   = {`BAR_FT_CPLD, 14'd0, 10'd1};
        cpl_beat.data[63:32]  = {i_pcie_id[7:0], i_pcie_id[15:8], 4'd0, 12'd4};
        cpl_beat.data[95:64]  = {i_rsp.ctx.req_id, i_rsp.ctx.tag, 1'b0, i_rsp.ctx.low_addr};
        cpl_beat.data[127:96] = bar_pkg::dword_swap(i_rsp.data);
        cpl_beat.keepdw       = 4'hF;
        cpl_beat.last         = 1'b1;
    end

    // ------------------------------------------------------------
    // Completion FIFO
    // ------------------------------------------------------------
    assign pop        = o_tx_valid && i_tx_ready;
    assign o_tx_valid = (fifo_count != '0);
    assign o_tx       = fifo_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (i_rsp_valid) begin
            fifo_mem[wr_ptr] <= cpl_beat;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            fifo_count <= '0;
        end else begin
            if (i_rsp_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            fifo_count <= fifo_count + CNT_W'(i_rsp_valid) - CNT_W'(pop);
        end
    end

    // Slots held by reads in flight plus entries queued
    always_ff @(posedge clk) begin
        if (rst) begin
            reserved <= '0;
        end else begin
            reserved <= reserved + CNT_W'(i_rd_accept) - CNT_W'(pop);
        end
    end

    // Count a read accepted this cycle before it lands in reserved
    assign o_rd_credit = i_rd_accept ? (reserved < DEPTH_C - 1'b1) : (reserved < DEPTH_C);

    a_no_overflow: assert property (@(posedge clk) disable iff (rst)
        i_rsp_valid |-> (fifo_count < DEPTH_C));

    a_tx_stable: assert property (@(posedge clk) disable iff (rst)
        (o_tx_valid && !i_tx_ready) |=> (o_tx_valid && $stable(o_tx)));

endmodule

// ==== verilog/bar_responders.sv ====
`timescale 1ns/1ps
`include "bar_consts.svh"

module bar_responders (
    input  logic                clk,
    input  logic                rst,
    input  bar_pkg::wr_req_t    i_wr_req,
    input  logic                i_wr_valid,
    input  bar_pkg::rd_req_t    i_rd_req,
    input  logic                i_rd_valid,
    output bar_pkg::rd_rsp_t    o_rsp,
    output logic                o_rsp_valid
);

    localparam int LAT = `BAR_RSP_LATENCY;

    // Context pipeline, one stage per cycle of latency
    logic [LAT-1:0]     pipe_valid;
    logic [LAT-1:0]     pipe_loop;
    bar_pkg::dword_t    pipe_addr [LAT];
    bar_pkg::rd_ctx_t   pipe_ctx  [LAT];
    bar_pkg::dword_t    mem_data;

    // BAR 0 memory, writes to BAR 1 are ignored
    bar_mem_4k bar_mem_4k_inst (
        .clk        (clk),
        .i_wr_valid (i_wr_valid && i_wr_req.bar_hit[0]),
        .i_wr_addr  (i_wr_req.dw_addr),
        .i_wr_be    (i_wr_req.byte_en),
        .i_wr_data  (i_wr_req.data),
        .i_rd_valid (i_rd_valid && i_rd_req.bar_hit[0]),
        .i_rd_addr  (i_rd_req.addr[11:2]),
        .o_rd_data  (mem_data)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            pipe_valid <= '0;
        end else begin
            pipe_valid <= {pipe_valid[LAT-2:0], i_rd_valid};
        end
    end

    always_ff @(posedge clk) begin
        pipe_loop[0] <= i_rd_req.bar_hit[1];
        pipe_addr[0] <= i_rd_req.addr;
        pipe_ctx[0]  <= i_rd_req.ctx;
        for (int s = 1; s < LAT; s++) begin
            pipe_loop[s] <= pipe_loop[s-1];
            pipe_addr[s] <= pipe_addr[s-1];
            pipe_ctx[s]  <= pipe_ctx[s-1];
        end
    end

    // ------------------------------------------------------------
    // Response merge on the last stage
    // ------------------------------------------------------------
    assign o_rsp_valid = pipe_valid[LAT-1];
    assign o_rsp.ctx   = pipe_ctx[LAT-1];
    assign o_rsp.data  = pipe_loop[LAT-1] ? pipe_addr[LAT-1] : mem_data;

    a_one_bar: assert property (@(posedge clk) disable iff (rst)
        (i_rd_valid |-> (i_rd_req.bar_hit == bar_pkg::bar_hit_t'(1)) ||
                        (i_rd_req.bar_hit == bar_pkg::bar_hit_t'(2))) and
        (i_wr_valid |-> (i_wr_req.bar_hit == bar_pkg::bar_hit_t'(1)) ||
                        (i_wr_req.bar_hit == bar_pkg::bar_hit_t'(2))));

endmodule

// ==== verilog/bar_mem_4k.sv ====
`timescale 1ns/1ps
`include "bar_consts.svh"

module bar_mem_4k (
    input  logic                clk,
    input  logic                i_wr_valid,
    input  bar_pkg::dw_addr_t   i_wr_addr,
    input  bar_pkg::byte_en_t   i_wr_be,
    input  bar_pkg::dword_t     i_wr_data,
    input  logic                i_rd_valid,
    input  bar_pkg::dw_addr_t   i_rd_addr,
    output bar_pkg::dword_t     o_rd_data
);

    // Starts out all zero
    bar_pkg::dword_t mem [`BAR_MEM_DEPTH] = '{default: '0};

    bar_pkg::dword_t rd_stage;

    // ------------------------------------------------------------
    // Write port with byte lanes
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (i_wr_valid) begin
            for (int b = 0; b < 4; b++) begin
                if (i_wr_be[b]) begin
                    mem[i_wr_addr][8*b +: 8] <= i_wr_data[8*b +: 8];
                end
            end
        end
    end

    // ------------------------------------------------------------
    // Read port, array read then output register
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (i_rd_valid) begin
            rd_stage <= mem[i_rd_addr];
        end
    end

    always_ff @(posedge clk) begin
        o_rd_data <= rd_stage;
    end

endmodule

// ==== verilog/tlp_bar_rx.sv ====
`timescale 1ns/1ps
`include "bar_consts.svh"

module tlp_bar_rx (
    input  logic                clk,
    input  logic                rst,
    input  bar_pkg::tlp_beat_t  i_rx,
    input  logic                i_rx_valid,
    input  logic                i_bar_en,
    input  logic                i_rd_credit,
    output bar_pkg::wr_req_t    o_wr_req,
    output logic                o_wr_valid,
    output bar_pkg::rd_req_t    o_rd_req,
    output logic                o_rd_valid
);

    // ------------------------------------------------------------
    // Header fields of a 3-DW request
    // ------------------------------------------------------------
    logic [7:0]         fmt_type;
    logic               len_one;
    logic               hit_ok;
    bar_pkg::dword_t    req_addr;
    bar_pkg::rx_kind_e  kind;

    assign fmt_type = i_rx.data[31:24];
    assign len_one  = (i_rx.data[9:0] == 10'd1);
    assign req_addr = {i_rx.data[95:66], 2'b00};

    // Only BAR 0 and BAR 1 are served
    assign hit_ok = (i_rx.bar_hit == bar_pkg::bar_hit_t'(1)) ||
                    (i_rx.bar_hit == bar_pkg::bar_hit_t'(2));

    always_comb begin
        kind = bar_pkg::RX_NONE;
        if (i_rx_valid && i_bar_en && i_rx.first && i_rx.last && len_one && hit_ok) begin
            if (fmt_type == `BAR_FT_MRD32) begin
                kind = bar_pkg::RX_READ;
            end else if (fmt_type == `BAR_FT_MWR32) begin
                kind = bar_pkg::RX_WRITE;
            end
        end
    end

    // ------------------------------------------------------------
    // Request strobes
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            o_wr_valid <= 1'b0;
            o_rd_valid <= 1'b0;
        end else begin
            o_wr_valid <= (kind == bar_pkg::RX_WRITE);
            // Reads with no credit left are dropped here
            o_rd_valid <= (kind == bar_pkg::RX_READ) && i_rd_credit;
        end
    end

    // Payload capture
    always_ff @(posedge clk) begin
        if (kind == bar_pkg::RX_WRITE) begin
            o_wr_req.bar_hit <= i_rx.bar_hit;
            o_wr_req.dw_addr <= req_addr[11:2];
            o_wr_req.byte_en <= i_rx.data[35:32];
            o_wr_req.data    <= bar_pkg::dword_swap(i_rx.data[127:96]);
        end
        if (kind == bar_pkg::RX_READ) begin
            o_rd_req.bar_hit      <= i_rx.bar_hit;
            o_rd_req.addr         <= req_addr;
            o_rd_req.ctx.req_id   <= i_rx.data[63:48];
            o_rd_req.ctx.tag      <= i_rx.data[47:40];
            o_rd_req.ctx.low_addr <= req_addr[6:0];
        end
    end

    a_one_strobe: assert property (@(posedge clk) disable iff (rst)
        !(o_wr_valid && o_rd_valid));

endmodule

// ==== verilog/bar_pkg.sv ====
`include "bar_consts.svh"

package bar_pkg;

    typedef logic [`BAR_DW_W-1:0]               dword_t;
    typedef logic [`BAR_DW_W/8-1:0]             byte_en_t;
    typedef logic [`BAR_HIT_W-1:0]              bar_hit_t;
    typedef logic [`BAR_ID_W-1:0]               pcie_id_t;
    typedef logic [`BAR_TAG_W-1:0]              tag_t;
    typedef logic [$clog2(`BAR_MEM_DEPTH)-1:0]  dw_addr_t;

    // Incoming beat, tuser split into named fields
    typedef struct packed {
        logic [`BAR_TLP_W-1:0]  data;
        logic [`BAR_KEEP_W-1:0] keepdw;
        logic                   first;
        logic                   last;
        bar_hit_t               bar_hit;
    } tlp_beat_t;

    typedef struct packed {
        logic [`BAR_TLP_W-1:0]  data;
        logic [`BAR_KEEP_W-1:0] keepdw;
        logic                   last;
    } tlp_out_t;

    typedef struct packed {
        bar_hit_t   bar_hit;
        dw_addr_t   dw_addr;
        byte_en_t   byte_en;
        dword_t     data;
    } wr_req_t;

    // Travels with a read and comes back with its response
    typedef struct packed {
        pcie_id_t                   req_id;
        tag_t                       tag;
        logic [`BAR_LOWADDR_W-1:0]  low_addr;
    } rd_ctx_t;

    typedef struct packed {
        bar_hit_t   bar_hit;
        dword_t     addr;
        rd_ctx_t    ctx;
    } rd_req_t;

    typedef struct packed {
        rd_ctx_t    ctx;
        dword_t     data;
    } rd_rsp_t;

    typedef enum logic [1:0] {
        RX_NONE,
        RX_READ,
        RX_WRITE
    } rx_kind_e;

    // TLP payload bytes are big-endian within each DW
    function automatic dword_t dword_swap(dword_t d);
        return {d[7:0], d[15:8], d[23:16], d[31:24]};
    endfunction

endpackage

// ==== verilog/bar_consts.svh ====
`ifndef BAR_CONSTS_SVH
`define BAR_CONSTS_SVH

// ------------------------------------------------------------
// Stream and field widths
// ------------------------------------------------------------
`define BAR_TLP_W        128
`define BAR_DW_W         32
`define BAR_KEEP_W       4
`define BAR_HIT_W        7
`define BAR_ID_W         16
`define BAR_TAG_W        8
`define BAR_LOWADDR_W    7

// ------------------------------------------------------------
// TLP fmt/type bytes
// ------------------------------------------------------------
`define BAR_FT_MRD32     8'h00
`define BAR_FT_MWR32     8'h40
`define BAR_FT_CPLD      8'h4A

// Depths and latencies
`define BAR_MEM_DEPTH    1024
`define BAR_CPL_DEPTH    8
`define BAR_RSP_LATENCY  2

`endif
